// ==== source/lease_defs.svh ====
/* sets and ways must be powers of two; a lease fits the low data byte of an
   OP_LLT write, so LEASE_BW stays at 8 or below */
`ifndef LEASE_DEFS_SVH
`define LEASE_DEFS_SVH

// cache geometry
// -------------------------------------------------------------------------
`define LEASE_N_SETS       4                        // one bank per set
`define LEASE_N_WAYS       4                        // ways per set
`define LEASE_SET_BW       $clog2(`LEASE_N_SETS)
`define LEASE_WAY_BW       $clog2(`LEASE_N_WAYS)

// lease counters and lookup table
// -------------------------------------------------------------------------
`define LEASE_BW           8                        // lease counter width
`define LEASE_LLT_ENTRIES  8                        // table depth
`define LEASE_LLT_BW       $clog2(`LEASE_LLT_ENTRIES)
`define LEASE_REF_BW       16                       // reference address width

// backup random eviction
`define LEASE_LFSR_SEED    8'hA1                    // must be nonzero

`endif

// ==== source/lease_pkg.sv ====
/* types shared by lookup, banks and collector */
`default_nettype none
`include "lease_defs.svh"

package lease_pkg;

	// request opcodes
	typedef enum logic [1:0] {
		OP_CFG  = 2'd0,     // default lease <= data low byte
		OP_LLT  = 2'd1,     // table entry data[15:8] <= ref and data low byte
		OP_HIT  = 2'd2,     // renew lease of the named way
		OP_MISS = 2'd3      // pick a victim and install the lease
	} lease_op_e;

	// answer of one set bank, one cycle after the stage advanced
	typedef struct packed {
		logic                     valid;      // only the addressed bank
		logic [`LEASE_WAY_BW-1:0] way;        // renewed or victim way
		logic                     swap;       // line allocated on a miss
		logic                     expired;    // victim was an expired way
		logic                     multi;      // more than one way had expired
		logic                     random;     // victim came from the lfsr
		logic                     dflt;       // lease came from the default register
	} bank_resp_t;

endpackage

`default_nettype wire

// ==== source/lease_stage_if.sv ====
/* carries one looked-up request to every bank; advance comes back from the
   collector and freezes all stages together */
`timescale 1ns/100ps
`default_nettype none
`include "lease_defs.svh"

interface lease_stage_if;

	logic                     valid;      // stage holds a request
	lease_pkg::lease_op_e     op;
	logic [`LEASE_SET_BW-1:0] set;        // addressed set, selects the bank
	logic [`LEASE_WAY_BW-1:0] way;        // named way for hits
	logic [`LEASE_BW-1:0]     lease;      // resolved lease
	logic                     dflt;       // lease taken from default register
	logic                     advance;    // pipeline moves on this cycle

	// lookup stage writes the stage register
	modport lookup_mp (
		output valid, op, set, way, lease, dflt,
		input  advance
	);

	// banks only look
	modport bank_mp (
		input valid, op, set, way, lease, dflt, advance
	);

	// collector owns the stall
	modport collect_mp (
		output advance
	);

endinterface

`default_nettype wire

// ==== source/lease_lookup.sv ====
/* table and default lease writes take effect at acceptance; table search is
   lowest index first over valid entries only */
`timescale 1ns/100ps
`default_nettype none
`include "lease_defs.svh"

module lease_lookup (
	input  logic                        clock_i,
	input  logic                        resetn_i,
	input  logic                        req_valid_i,
	output logic                        req_ready_o,
	input  lease_pkg::lease_op_e        req_op_i,
	input  logic [`LEASE_SET_BW-1:0]    req_set_i,
	input  logic [`LEASE_WAY_BW-1:0]    req_way_i,
	input  logic [`LEASE_REF_BW-1:0]    req_ref_i,
	input  logic [15:0]                 req_data_i,
	lease_stage_if.lookup_mp            stage_o
);

	logic                           accept;                     // request transfers
	logic [`LEASE_LLT_BW-1:0]       llt_idx;                    // entry addressed by OP_LLT
	logic [`LEASE_BW-1:0]           dflt_lease_q;
	logic [`LEASE_LLT_ENTRIES-1:0]  llt_valid_q;
	logic [`LEASE_BW-1:0]           llt_lease_q [`LEASE_LLT_ENTRIES];
	logic [`LEASE_REF_BW-1:0]       llt_ref_q   [`LEASE_LLT_ENTRIES];
	logic                           in_valid_q;
	lease_pkg::lease_op_e           in_op_q;
	logic [`LEASE_SET_BW-1:0]       in_set_q;
	logic [`LEASE_WAY_BW-1:0]       in_way_q;
	logic [`LEASE_REF_BW-1:0]       in_ref_q;
	logic                           llt_hit;
	logic [`LEASE_BW-1:0]           llt_lease;
	logic                           is_access;                  // hit or miss

	assign req_ready_o = stage_o.advance;                       // whole pipe stalls as one
	assign accept      = req_valid_i & req_ready_o;
	assign llt_idx     = req_data_i[8 +: `LEASE_LLT_BW];

	// configuration writes
	// -------------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			dflt_lease_q <= '0;
			llt_valid_q  <= '0;
		end else if (accept) begin
			if (req_op_i == lease_pkg::OP_CFG)
				dflt_lease_q <= req_data_i[`LEASE_BW-1:0];
			if (req_op_i == lease_pkg::OP_LLT)
				llt_valid_q[llt_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clock_i) begin
		if (accept && req_op_i == lease_pkg::OP_LLT) begin
			llt_lease_q[llt_idx] <= req_data_i[`LEASE_BW-1:0];
			llt_ref_q[llt_idx]   <= req_ref_i;
		end
	end

	// input register
	always_ff @(posedge clock_i) begin
		if (!resetn_i)
			in_valid_q <= 1'b0;
		else if (stage_o.advance)
			in_valid_q <= accept;                               // bubble when nothing offered
	end

	always_ff @(posedge clock_i) begin
		if (stage_o.advance) begin
			in_op_q  <= req_op_i;
			in_set_q <= req_set_i;
			in_way_q <= req_way_i;
			in_ref_q <= req_ref_i;
		end
	end

	// lease resolution
	// -------------------------------------------------------------------------
	always_comb begin
		llt_hit   = 1'b0;
		llt_lease = dflt_lease_q;                               // fallback on table miss
		for (int i = `LEASE_LLT_ENTRIES - 1; i >= 0; i--) begin // downward so lowest wins
			if (llt_valid_q[i] && llt_ref_q[i] == in_ref_q) begin
				llt_hit   = 1'b1;
				llt_lease = llt_lease_q[i];
			end
		end
	end

	assign is_access = (in_op_q == lease_pkg::OP_HIT) || (in_op_q == lease_pkg::OP_MISS);

	// output register, seen by all banks
	always_ff @(posedge clock_i) begin
		if (!resetn_i)
			stage_o.valid <= 1'b0;
		else if (stage_o.advance)
			stage_o.valid <= in_valid_q;
	end

	always_ff @(posedge clock_i) begin
		if (stage_o.advance) begin
			stage_o.op    <= in_op_q;
			stage_o.set   <= in_set_q;
			stage_o.way   <= in_way_q;
			stage_o.lease <= llt_lease;
			stage_o.dflt  <= is_access & ~llt_hit;              // config ops answer zero
		end
	end

endmodule

`default_nettype wire

// ==== source/lease_set_bank.sv ====
/* leases of one set; every hit or miss in any set ages them, victim choice
   looks at the leases as they were before that aging */
`timescale 1ns/100ps
`default_nettype none
`include "lease_defs.svh"

module lease_set_bank #(
	parameter int SET_INDEX = 0
) (
	input  logic                    clock_i,
	input  logic                    resetn_i,
	lease_stage_if.bank_mp          stage_i,
	output lease_pkg::bank_resp_t   resp_o
);

	localparam int WAY_BW = `LEASE_WAY_BW;

	logic [`LEASE_BW-1:0]       lease_q [`LEASE_N_WAYS];
	logic [WAY_BW-1:0]          fill_ptr_q;                 // cold start fill way
	logic                       full_q;                     // set filled once
	logic [7:0]                 lfsr_q;
	logic [7:0]                 lfsr_next;
	logic [`LEASE_N_WAYS-1:0]   expired;
	logic [WAY_BW-1:0]          exp_way;                    // lowest expired way
	logic                       any_exp;
	logic                       multi_exp;
	logic                       own;                        // request addresses this set
	logic                       access;                     // hit or miss anywhere
	logic                       own_hit;
	logic                       own_miss;
	logic                       alloc;                      // miss with nonzero lease
	logic [WAY_BW-1:0]          victim;
	logic                       take_exp;
	logic                       take_rand;
	logic                       valid_q;
	logic [WAY_BW-1:0]          way_q;
	logic                       swap_q;
	logic                       expired_q;
	logic                       multi_q;
	logic                       random_q;
	logic                       dflt_q;

	assign own      = stage_i.valid && (stage_i.set == SET_INDEX[`LEASE_SET_BW-1:0]);
	assign access   = stage_i.valid &&
	                  (stage_i.op == lease_pkg::OP_HIT || stage_i.op == lease_pkg::OP_MISS);
	assign own_hit  = own && stage_i.op == lease_pkg::OP_HIT;
	assign own_miss = own && stage_i.op == lease_pkg::OP_MISS;
	assign alloc    = own_miss && stage_i.lease != '0;

	// galois lfsr, taps 8,6,5,4
	assign lfsr_next = {1'b0, lfsr_q[7:1]} ^ (lfsr_q[0] ? 8'hB8 : 8'h00);

	// expired ways, scanned from the top so the lowest index is kept
	// -------------------------------------------------------------------------
	always_comb begin
		any_exp   = 1'b0;
		multi_exp = 1'b0;
		exp_way   = '0;
		for (int w = `LEASE_N_WAYS - 1; w >= 0; w--) begin
			expired[w] = (lease_q[w] == '0);
			if (expired[w]) begin
				multi_exp = multi_exp | any_exp;        // second one seen
				any_exp   = 1'b1;
				exp_way   = w[WAY_BW-1:0];
			end
		end
	end

	// victim order: fill pointer, then expired, then random
	always_comb begin
		victim    = fill_ptr_q;
		take_exp  = 1'b0;
		take_rand = 1'b0;
		if (full_q) begin
			if (any_exp) begin
				victim   = exp_way;
				take_exp = 1'b1;
			end else begin
				victim    = lfsr_q[WAY_BW-1:0];
				take_rand = 1'b1;
			end
		end
	end

	// lease state
	// -------------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			for (int w = 0; w < `LEASE_N_WAYS; w++)
				lease_q[w] <= '0;
			fill_ptr_q <= '0;
			full_q     <= 1'b0;
			lfsr_q     <= `LEASE_LFSR_SEED;
			valid_q    <= 1'b0;
		end else if (stage_i.advance) begin
			valid_q <= own;
			if (access) begin                           // global aging
				for (int w = 0; w < `LEASE_N_WAYS; w++)
					if (lease_q[w] != '0)
						lease_q[w] <= lease_q[w] - 1'b1;
			end
			if (own_hit)
				lease_q[stage_i.way] <= stage_i.lease;  // renewal overrides aging
			if (alloc) begin
				lease_q[victim] <= stage_i.lease;
				if (!full_q) begin
					fill_ptr_q <= fill_ptr_q + 1'b1;
					if (&fill_ptr_q)
						full_q <= 1'b1;                 // last way just filled
				end
				if (take_rand)
					lfsr_q <= lfsr_next;                // steps only when used
			end
		end
	end

	// response payload
	always_ff @(posedge clock_i) begin
		if (stage_i.advance) begin
			way_q     <= '0;
			swap_q    <= 1'b0;
			expired_q <= 1'b0;
			multi_q   <= 1'b0;
			random_q  <= 1'b0;
			dflt_q    <= (own_hit || own_miss) && stage_i.dflt;
			if (own_hit)
				way_q <= stage_i.way;
			if (alloc) begin
				way_q     <= victim;
				swap_q    <= 1'b1;
				expired_q <= take_exp;
				multi_q   <= take_exp & multi_exp;
				random_q  <= take_rand;
			end
		end
	end

	assign resp_o = '{valid: valid_q, way: way_q, swap: swap_q, expired: expired_q,
	                  multi: multi_q, random: random_q, dflt: dflt_q};

endmodule

`default_nettype wire

// ==== source/lease_resp_collect.sv ====
/* at most one bank answers per cycle; the answer is held while resp_ready_i
   is low and the whole pipe stalls with it */
`timescale 1ns/100ps
`default_nettype none
`include "lease_defs.svh"

module lease_resp_collect (
	input  logic                        clock_i,
	input  logic                        resetn_i,
	lease_stage_if.collect_mp           stage_i,
	input  lease_pkg::bank_resp_t       bank_resp_i [`LEASE_N_SETS],
	input  logic                        resp_ready_i,
	output logic                        resp_valid_o,
	output logic [`LEASE_WAY_BW-1:0]    resp_way_o,
	output logic                        resp_swap_o,
	output logic                        resp_expired_o,
	output logic                        resp_multi_o,
	output logic                        resp_random_o,
	output logic                        resp_default_o
);

	lease_pkg::bank_resp_t  merged;                     // or of valid bank answers

	// merge
	always_comb begin
		merged = '0;
		for (int s = 0; s < `LEASE_N_SETS; s++)
			if (bank_resp_i[s].valid)
				merged = merged | bank_resp_i[s];
	end

	// stall only when a held answer is refused
	assign stage_i.advance = ~resp_valid_o | resp_ready_i;

	// output register
	// -------------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i)
			resp_valid_o <= 1'b0;
		else if (stage_i.advance)
			resp_valid_o <= merged.valid;
	end

	always_ff @(posedge clock_i) begin
		if (stage_i.advance) begin
			resp_way_o     <= merged.way;
			resp_swap_o    <= merged.swap;
			resp_expired_o <= merged.expired;
			resp_multi_o   <= merged.multi;
			resp_random_o  <= merged.random;
			resp_default_o <= merged.dflt;
		end
	end

endmodule

`default_nettype wire

// ==== source/lease_cache_top.sv ====
/* valid/ready on both sides, one response per request in order; req fields
   must hold while req_valid_i is high */
`timescale 1ns/100ps
`default_nettype none
`include "lease_defs.svh"

module lease_cache_top (
	input  logic                        clock_i,
	input  logic                        resetn_i,
	// request side
	input  logic                        req_valid_i,
	output logic                        req_ready_o,
	input  lease_pkg::lease_op_e        req_op_i,
	input  logic [`LEASE_SET_BW-1:0]    req_set_i,
	input  logic [`LEASE_WAY_BW-1:0]    req_way_i,
	input  logic [`LEASE_REF_BW-1:0]    req_ref_i,
	input  logic [15:0]                 req_data_i,
	// response side
	input  logic                        resp_ready_i,
	output logic                        resp_valid_o,
	output logic [`LEASE_WAY_BW-1:0]    resp_way_o,
	output logic                        resp_swap_o,
	output logic                        resp_expired_o,
	output logic                        resp_multi_o,
	output logic                        resp_random_o,
	output logic                        resp_default_o
);

	lease_stage_if          stage_if ();                // lookup -> banks, advance back
	lease_pkg::bank_resp_t  bank_resp [`LEASE_N_SETS];

	// stage 1, request register and lease lookup
	lease_lookup lookup_i (
		.clock_i     (clock_i),
		.resetn_i    (resetn_i),
		.req_valid_i (req_valid_i),
		.req_ready_o (req_ready_o),
		.req_op_i    (req_op_i),
		.req_set_i   (req_set_i),
		.req_way_i   (req_way_i),
		.req_ref_i   (req_ref_i),
		.req_data_i  (req_data_i),
		.stage_o     (stage_if.lookup_mp)
	);

	// stage 2, one lease bank per set
	// -------------------------------------------------------------------------
	for (genvar g = 0; g < `LEASE_N_SETS; g++) begin : gen_bank
		lease_set_bank #(
			.SET_INDEX (g)
		) bank_i (
			.clock_i  (clock_i),
			.resetn_i (resetn_i),
			.stage_i  (stage_if.bank_mp),
			.resp_o   (bank_resp[g])
		);
	end

	// stage 3, response register and stall source
	lease_resp_collect collect_i (
		.clock_i        (clock_i),
		.resetn_i       (resetn_i),
		.stage_i        (stage_if.collect_mp),
		.bank_resp_i    (bank_resp),
		.resp_ready_i   (resp_ready_i),
		.resp_valid_o   (resp_valid_o),
		.resp_way_o     (resp_way_o),
		.resp_swap_o    (resp_swap_o),
		.resp_expired_o (resp_expired_o),
		.resp_multi_o   (resp_multi_o),
		.resp_random_o  (resp_random_o),
		.resp_default_o (resp_default_o)
	);

endmodule

`default_nettype wire

// ==== tb/lease_cache_sva.sv ====
/* protocol checks on the top-level ports; tracks only request and response
   counts, no data model */
`timescale 1ns/100ps
`default_nettype none
`include "lease_defs.svh"

module lease_cache_sva (
	input  logic                        clock_i,
	input  logic                        resetn_i,
	input  logic                        req_valid_i,
	input  logic                        req_ready_i,
	input  logic                        resp_valid_i,
	input  logic                        resp_ready_i,
	input  logic [`LEASE_WAY_BW-1:0]    resp_way_i,
	input  logic                        resp_swap_i,
	input  logic                        resp_expired_i,
	input  logic                        resp_multi_i,
	input  logic                        resp_random_i,
	input  logic                        resp_default_i
);

	logic [`LEASE_WAY_BW+4:0]   resp_fields;               // way and the five flags
	logic [7:0]                 outstanding;               // accepted, not yet answered

	assign resp_fields = {resp_way_i, resp_swap_i, resp_expired_i, resp_multi_i,
	                      resp_random_i, resp_default_i};

	always_ff @(posedge clock_i) begin
		if (!resetn_i)
			outstanding <= '0;
		else
			outstanding <= outstanding + {7'd0, req_valid_i & req_ready_i}
			               - {7'd0, resp_valid_i & resp_ready_i};
	end

	// a refused answer stays put
	// -------------------------------------------------------------------------
	a_resp_hold: assert property (@(posedge clock_i) disable iff (!resetn_i)
		resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_fields))
		else $error("response changed while resp_ready_i was low");

	a_resp_count: assert property (@(posedge clock_i) disable iff (!resetn_i)
		resp_valid_i && resp_ready_i |-> outstanding != 8'd0)   // never ahead of requests
		else $error("response taken without an outstanding request");

endmodule

bind lease_cache_top lease_cache_sva sva_i (
	.clock_i        (clock_i),
	.resetn_i       (resetn_i),
	.req_valid_i    (req_valid_i),
	.req_ready_i    (req_ready_o),
	.resp_valid_i   (resp_valid_o),
	.resp_ready_i   (resp_ready_i),
	.resp_way_i     (resp_way_o),
	.resp_swap_i    (resp_swap_o),
	.resp_expired_i (resp_expired_o),
	.resp_multi_i   (resp_multi_o),
	.resp_random_i  (resp_random_o),
	.resp_default_i (resp_default_o)
);

`default_nettype wire

// ==== tb/lease_cache_tb.sv ====
/* reads tb/lease_golden.txt relative to the project root; N_VEC must match its
   line count, responses are checked in request order under random back-pressure */
`timescale 1ns/100ps
`default_nettype none
`include "lease_defs.svh"

module lease_cache_tb;

	localparam int N_VEC       = 36;                        // requests in the golden file
	localparam int FIELDS      = 11;                        // words per golden line
	localparam int CYCLE_LIMIT = N_VEC * 8 + 100;
	localparam int RESP_BW     = `LEASE_WAY_BW + 5;         // way plus five flags

	logic                        clock_i;
	logic                        resetn_i;
	logic                        req_valid_i;
	logic                        req_ready_o;
	lease_pkg::lease_op_e        req_op_i;
	logic [`LEASE_SET_BW-1:0]    req_set_i;
	logic [`LEASE_WAY_BW-1:0]    req_way_i;
	logic [`LEASE_REF_BW-1:0]    req_ref_i;
	logic [15:0]                 req_data_i;
	logic                        resp_ready_i;
	logic                        resp_valid_o;
	logic [`LEASE_WAY_BW-1:0]    resp_way_o;
	logic                        resp_swap_o;
	logic                        resp_expired_o;
	logic                        resp_multi_o;
	logic                        resp_random_o;
	logic                        resp_default_o;

	logic [15:0]    golden_mem [N_VEC * FIELDS];            // op set way ref data, then answer
	logic [31:0]    rnd_state;
	int             sent;                                   // requests accepted
	int             seen;                                   // responses checked
	int             cycles;
	logic           req_fire;
	logic           resp_fire;

	lease_cache_top lease_cache_top_i (.*);

	initial clock_i = 1'b0;
	always #10 clock_i = ~clock_i;                          // 20 ns period

	// helpers
	// -------------------------------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic pick_ready();
		rnd_state    = xorshift32(rnd_state);
		resp_ready_i = (rnd_state[1:0] != 2'b00);           // ready about 3 cycles in 4
	endtask

	task automatic drive_request(input int idx);
		int base;
		base        = idx * FIELDS;
		req_op_i    = lease_pkg::lease_op_e'(golden_mem[base][1:0]);
		req_set_i   = golden_mem[base + 1][`LEASE_SET_BW-1:0];
		req_way_i   = golden_mem[base + 2][`LEASE_WAY_BW-1:0];
		req_ref_i   = golden_mem[base + 3];
		req_data_i  = golden_mem[base + 4];
		req_valid_i = 1'b1;
	endtask

	task automatic check_response(input int idx);
		int                 base;
		logic [RESP_BW-1:0] got;                            // way then swap expired multi random dflt
		logic [RESP_BW-1:0] exp;
		base = idx * FIELDS;
		got  = {resp_way_o, resp_swap_o, resp_expired_o, resp_multi_o,
		        resp_random_o, resp_default_o};
		exp  = {golden_mem[base + 5][`LEASE_WAY_BW-1:0], golden_mem[base + 6][0],
		        golden_mem[base + 7][0], golden_mem[base + 8][0],
		        golden_mem[base + 9][0], golden_mem[base + 10][0]};
		assert (got == exp) else
			fail_run($sformatf("mismatch at %0t: response %0d got %b, expected %b",
			                   $time, idx, got, exp));
	endtask

	// stimulus and checking
	// -------------------------------------------------------------------------
	initial begin
		resetn_i     = 1'b0;
		req_valid_i  = 1'b0;
		req_op_i     = lease_pkg::OP_CFG;
		req_set_i    = '0;
		req_way_i    = '0;
		req_ref_i    = '0;
		req_data_i   = '0;
		resp_ready_i = 1'b0;
		rnd_state    = 32'd62137;
		sent         = 0;
		seen         = 0;
		cycles       = 0;
		$readmemh("tb/lease_golden.txt", golden_mem);

		repeat (16) @(posedge clock_i);
		#1;
		resetn_i = 1'b1;
		@(negedge clock_i);
		assert (req_ready_o && !resp_valid_o) else
			fail_run("ports not idle after reset, req_ready_o low or resp_valid_o high");

		@(posedge clock_i);
		#1;
		drive_request(0);
		pick_ready();

		while (seen < N_VEC) begin
			@(negedge clock_i);                             // handshakes are stable here
			req_fire  = req_valid_i & req_ready_o;
			resp_fire = resp_valid_o & resp_ready_i;
			if (resp_fire) begin
				check_response(seen);
				seen++;
			end
			cycles++;
			assert (cycles <= CYCLE_LIMIT) else
				fail_run($sformatf("timeout after %0d cycles with %0d of %0d responses",
				                   cycles, seen, N_VEC));
			@(posedge clock_i);
			#1;
			if (req_fire)
				sent++;
			if (sent < N_VEC)
				drive_request(sent);                        // held until accepted
			else
				req_valid_i = 1'b0;
			pick_ready();
		end

		// drain, nothing more may come out
		@(posedge clock_i);
		#1;
		req_valid_i  = 1'b0;
		resp_ready_i = 1'b1;
		repeat (8) begin
			@(negedge clock_i);
			assert (!resp_valid_o) else
				fail_run("a response appeared after the last expected one");
		end

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== lease_cache.f ====
+incdir+source
source/lease_pkg.sv
source/lease_stage_if.sv
source/lease_lookup.sv
source/lease_set_bank.sv
source/lease_resp_collect.sv
source/lease_cache_top.sv
tb/lease_cache_sva.sv
tb/lease_cache_tb.sv

// ==== run_lease_cache.sh ====
#!/bin/sh
# builds the lease cache testbench with verilator and runs it
# exit status is the simulator's, nonzero on any failed check

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f lease_cache.f --top-module lease_cache_tb \
	-Mdir obj_dir -o lease_cache_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/lease_cache_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation ended with status $status"
fi
exit "$status"

// ==== tb/lease_golden.txt ====
// op set way ref data | way swap expired multi random default, all hex
// op 0 default lease write, 1 table write (data[10:8] entry, data[7:0] lease), 2 hit, 3 miss
0 0 0 0000 0014 0 0 0 0 0 0
1 0 0 1000 0000 0 0 0 0 0 0
1 0 0 2000 0103 0 0 0 0 0 0
1 0 0 3000 0206 0 0 0 0 0 0
3 0 0 0a00 0000 0 1 0 0 0 1
3 0 0 0a01 0000 1 1 0 0 0 1
3 0 0 0a02 0000 2 1 0 0 0 1
3 0 0 0a03 0000 3 1 0 0 0 1
3 1 0 1000 0000 0 0 0 0 0 0
3 1 0 0b00 0000 0 1 0 0 0 1
3 2 0 3000 0000 0 1 0 0 0 0
3 2 0 3000 0000 1 1 0 0 0 0
3 2 0 3000 0000 2 1 0 0 0 0
3 2 0 3000 0000 3 1 0 0 0 0
2 2 1 2000 0000 1 0 0 0 0 0
2 2 3 0c00 0000 3 0 0 0 0 1
2 0 2 2000 0000 2 0 0 0 0 0
3 2 0 2000 0000 0 1 1 0 0 0
2 1 0 3000 0000 0 0 0 0 0 0
3 2 0 0d00 0000 1 1 1 1 0 1
2 0 2 0e00 0000 2 0 0 0 0 1
3 0 0 0e01 0000 1 1 0 0 1 1
3 0 0 2000 0000 0 1 0 0 1 0
3 0 0 3000 0000 0 1 0 0 1 0
3 0 0 0f00 0000 2 1 0 0 1 1
1 0 0 2000 0109 0 0 0 0 0 0
2 2 0 2000 0000 0 0 0 0 0 0
2 2 2 2000 0000 2 0 0 0 0 0
3 3 0 3000 0000 0 1 0 0 0 0
3 3 0 0a00 0000 1 1 0 0 0 1
3 2 0 3000 0000 1 1 0 0 1 0
3 0 0 0f01 0000 0 1 1 1 0 1
0 0 0 0000 0000 0 0 0 0 0 0
3 3 0 0b00 0000 0 0 0 0 0 1
3 3 0 3000 0000 2 1 0 0 0 0
3 2 0 2000 0000 0 1 0 0 1 0
